// File: compile.f
logic/stm_pkg.sv
logic/pipe_divider.sv
logic/sys_time_counter.sv
logic/stm_settings.sv
logic/stm_timer.sv
logic/stm_segment_select.sv
logic/stm_top.sv
testbench/stm_top_sva.sv
testbench/stm_top_tb.sv

// File: testbench/stm_top_tb.sv
`default_nettype none

module stm_top_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int DIV_LATENCY = 50;
  localparam int IDX_DELAY   = 2 * DIV_LATENCY + 4;  // idx_out lags sys_time by this much
  localparam int TIMEOUT     = 500;
  localparam int ROUNDS      = 4;

  logic                            CLK;
  logic                            rst_n;
  logic                            time_load;
  logic [stm_pkg::SYS_TIME_W-1:0]  time_value;
  logic                            cfg_we;
  logic [stm_pkg::CFG_ADDR_W-1:0]  cfg_addr;
  logic [stm_pkg::FREQ_DIV_W-1:0]  cfg_wdata;
  logic                            update_req;
  logic [stm_pkg::SEGMENT_W-1:0]   req_segment;
  wire  [stm_pkg::CYCLE_W-1:0]     idx_out;
  wire  [stm_pkg::SEGMENT_W-1:0]   active_segment;
  wire                             update_done;

  int                              error_count;
  bit                              check_en;
  bit                              timed_out;
  logic [stm_pkg::SYS_TIME_W-1:0]  model_time;
  logic [stm_pkg::SYS_TIME_W-1:0]  time_hist [$];  // Entry 0 is the newest
  int unsigned                     wr_cycle [stm_pkg::NUM_SEGMENT];
  int unsigned                     wr_freq  [stm_pkg::NUM_SEGMENT];
  int unsigned                     use_cycle [stm_pkg::NUM_SEGMENT];
  int unsigned                     use_freq  [stm_pkg::NUM_SEGMENT];
  int unsigned                     model_segment;
  int unsigned                     pending_segment;

  stm_top #(
    .DIV_LATENCY(DIV_LATENCY)
  ) u_stm_top (
    .CLK           (CLK),
    .rst_n         (rst_n),
    .time_load     (time_load),
    .time_value    (time_value),
    .cfg_we        (cfg_we),
    .cfg_addr      (cfg_addr),
    .cfg_wdata     (cfg_wdata),
    .update_req    (update_req),
    .req_segment   (req_segment),
    .idx_out       (idx_out),
    .active_segment(active_segment),
    .update_done   (update_done)
  );

  always #5 CLK = ~CLK;

  // System time as the testbench expects it from its own loads
  always @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      model_time = '0;
      time_hist.delete();
    end else begin
      if (time_load) begin
        model_time = time_value;
      end else begin
        model_time = model_time + 1;
      end
      time_hist.push_front(model_time);
      if (time_hist.size() > IDX_DELAY + 1) begin
        void'(time_hist.pop_back());
      end
    end
  end

  function automatic logic [stm_pkg::CYCLE_W-1:0] expected_index(
    input logic [stm_pkg::SYS_TIME_W-1:0] t_val,
    input int unsigned                    fd,
    input int unsigned                    cyc
  );
    logic [63:0] coarse;
    coarse = (t_val >> stm_pkg::TIME_SHIFT) & ((64'd1 << stm_pkg::COARSE_TIME_W) - 64'd1);
    return stm_pkg::CYCLE_W'((coarse / 64'(fd)) % 64'(cyc + 1));
  endfunction

  task automatic compare_index();
    logic [stm_pkg::CYCLE_W-1:0] expected;
    if (check_en && time_hist.size() > IDX_DELAY) begin
      expected = expected_index(time_hist[IDX_DELAY], use_freq[model_segment],
                                use_cycle[model_segment]);
      if (idx_out !== expected) begin
        $display("MISMATCH at %0t: idx_out is %0d, expected %0d", $time, idx_out, expected);
        error_count++;
      end
    end
  endtask

  // Advance to the next falling edge, where outputs are stable
  task automatic next_cycle();
    @(negedge CLK);
    compare_index();
  endtask

  task automatic run_cycles(input int n);
    repeat (n) next_cycle();
  endtask

  task automatic write_setting(input int unsigned seg, input bit is_freq,
                               input int unsigned value);
    cfg_we    = 1'b1;
    cfg_addr  = stm_pkg::CFG_ADDR_W'({seg[0], is_freq});
    cfg_wdata = stm_pkg::FREQ_DIV_W'(value);
    next_cycle();
    cfg_we = 1'b0;
    if (is_freq) begin
      wr_freq[seg] = value;
    end else begin
      wr_cycle[seg] = value;
    end
  endtask

  task automatic request_update(input int unsigned seg);
    check_en        = 1'b0;  // Indices are mixed until the pipelines flush
    use_cycle       = wr_cycle;
    use_freq        = wr_freq;
    pending_segment = seg;
    update_req      = 1'b1;
    req_segment     = stm_pkg::SEGMENT_W'(seg);
    next_cycle();
    update_req = 1'b0;
  endtask

  task automatic wait_update_done();
    int n;
    n = 0;
    while (!update_done && n < TIMEOUT) begin
      next_cycle();
      n++;
    end
    if (update_done) begin
      check_en      = 1'b1;
      model_segment = pending_segment;
    end else begin
      $display("Timeout: update_done did not arrive within %0d cycles", TIMEOUT);
      error_count++;
      timed_out = 1'b1;
    end
  endtask

  // Load a time one coarse step before the index wraps and check the wrap cycle
  task automatic wrap_check();
    int unsigned fd;
    int unsigned cyc;
    int unsigned k;
    int unsigned frac;
    int unsigned steps;
    logic [63:0] coarse_start;
    fd           = use_freq[model_segment];
    cyc          = use_cycle[model_segment];
    k            = $urandom_range(1, 4000);
    frac         = $urandom_range(0, 255);
    coarse_start = 64'(k) * 64'(fd * (cyc + 1)) - 64'd1;
    time_load    = 1'b1;
    time_value   = (coarse_start << stm_pkg::TIME_SHIFT) | 64'(frac);
    next_cycle();
    time_load = 1'b0;
    steps     = (1 << stm_pkg::TIME_SHIFT) - frac;
    run_cycles(steps + IDX_DELAY - 1);
    if (idx_out !== stm_pkg::CYCLE_W'(cyc)) begin
      $display("MISMATCH at %0t: idx_out is %0d before the wrap, expected %0d",
               $time, idx_out, cyc);
      error_count++;
    end
    next_cycle();
    if (idx_out !== '0) begin
      $display("MISMATCH at %0t: idx_out is %0d at the wrap, expected 0", $time, idx_out);
      error_count++;
    end
  endtask

  initial begin
    int unsigned seg;
    int unsigned other;
    int          total;
    CLK         = 1'b0;
    rst_n       = 1'b0;
    time_load   = 1'b0;
    time_value  = '0;
    cfg_we      = 1'b0;
    cfg_addr    = '0;
    cfg_wdata   = '0;
    update_req  = 1'b0;
    req_segment = '0;
    error_count = 0;
    check_en    = 1'b0;
    timed_out   = 1'b0;
    for (int s = 0; s < stm_pkg::NUM_SEGMENT; s++) begin
      wr_cycle[s] = 0;
      wr_freq[s]  = 1;
    end
    use_cycle       = wr_cycle;
    use_freq        = wr_freq;
    model_segment   = 0;
    pending_segment = 0;
    void'($urandom(49745));

    repeat (5) @(negedge CLK);
    rst_n = 1'b1;

    for (int r = 0; r < ROUNDS; r++) begin
      seg   = (r + 1) % stm_pkg::NUM_SEGMENT;
      other = seg ^ 1;
      write_setting(seg, 1'b0, $urandom_range(0, 15));
      write_setting(seg, 1'b1, $urandom_range(1, 4));
      request_update(seg);
      run_cycles(2);

      // Ignored by the timer since it is busy
      update_req  = 1'b1;
      req_segment = stm_pkg::SEGMENT_W'(other);
      next_cycle();
      update_req = 1'b0;

      write_setting(seg, 1'b0, $urandom_range(0, 15));  // Pending, not yet in use
      write_setting(other, 1'b1, $urandom_range(1, 4));
      wait_update_done();
      if (timed_out) begin
        break;
      end

      run_cycles(40);
      write_setting(other, 1'b0, $urandom_range(0, 15));
      write_setting(other, 1'b1, $urandom_range(1, 4));
      run_cycles(40);
      wrap_check();
      run_cycles(20);
    end

    total = error_count + u_stm_top.u_stm_top_sva.fail_count;
    $display("Errors: %0d model, %0d assertion", error_count,
             u_stm_top.u_stm_top_sva.fail_count);
    if (total == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: testbench/stm_top_sva.sv
`default_nettype none

// Timing checks on the update handshake and the segment switch of stm_top
module stm_top_sva #(
  parameter int DIV_LATENCY = 50
) (
  input wire                           CLK,
  input wire                           rst_n,
  input wire                           update_req,
  input wire                           busy,
  input wire                           update_done,
  input wire [stm_pkg::SEGMENT_W-1:0]  req_segment,
  input wire [stm_pkg::SEGMENT_W-1:0]  active_segment
);
  timeunit 1ns;
  timeprecision 100ps;

  // update_done rises on edge 2L+3 after the accepting edge and is sampled one edge later
  localparam int DONE_SAMPLE = 2 * DIV_LATENCY + 4;

  int fail_count = 0;

  logic                          accept;
  logic [stm_pkg::SEGMENT_W-1:0] req_seen;

  assign accept = update_req && !busy;

  always @(posedge CLK) begin
    if (accept) begin
      req_seen <= req_segment;  // Segment of the request in flight
    end
  end

  a_reset_state: assert property (@(posedge CLK)
    !rst_n |=> (!update_done && !busy && active_segment == '0))
  else begin
    $error("State after reset is not idle with segment 0");
    fail_count++;
  end

  a_done_after_accept: assert property (@(posedge CLK) disable iff (!rst_n)
    accept |-> ##DONE_SAMPLE update_done)
  else begin
    $error("update_done missing after an accepted request");
    fail_count++;
  end

  // Also rules out a pulse caused by a request made while busy
  a_done_has_accept: assert property (@(posedge CLK) disable iff (!rst_n)
    update_done |-> $past(accept, DONE_SAMPLE))
  else begin
    $error("update_done without an accepted request at the expected distance");
    fail_count++;
  end

  a_done_single: assert property (@(posedge CLK) disable iff (!rst_n)
    update_done |=> !update_done)
  else begin
    $error("update_done is longer than one cycle");
    fail_count++;
  end

  a_segment_switch: assert property (@(posedge CLK) disable iff (!rst_n)
    update_done |=> (active_segment == $past(req_seen)))
  else begin
    $error("active_segment did not take the requested segment");
    fail_count++;
  end

  a_segment_hold: assert property (@(posedge CLK) disable iff (!rst_n)
    !update_done |=> $stable(active_segment))
  else begin
    $error("active_segment changed without update_done");
    fail_count++;
  end

endmodule

bind stm_top stm_top_sva #(
  .DIV_LATENCY(DIV_LATENCY)
) u_stm_top_sva (
  .CLK           (CLK),
  .rst_n         (rst_n),
  .update_req    (update_req),
  .busy          (busy),
  .update_done   (update_done),
  .req_segment   (req_segment),
  .active_segment(active_segment)
);

`default_nettype wire

// File: logic/stm_top.sv
`default_nettype none

module stm_top #(
  parameter int DIV_LATENCY = 50
) (
  input  wire                            CLK,
  input  wire                            rst_n,
  input  wire                            time_load,
  input  wire  [stm_pkg::SYS_TIME_W-1:0] time_value,
  input  wire                            cfg_we,
  input  wire  [stm_pkg::CFG_ADDR_W-1:0] cfg_addr,
  input  wire  [stm_pkg::FREQ_DIV_W-1:0] cfg_wdata,
  input  wire                            update_req,
  input  wire  [stm_pkg::SEGMENT_W-1:0]  req_segment,
  output wire  [stm_pkg::CYCLE_W-1:0]    idx_out,
  output wire  [stm_pkg::SEGMENT_W-1:0]  active_segment,
  output wire                            update_done
);

  wire [stm_pkg::SYS_TIME_W-1:0] sys_time;
  wire [stm_pkg::CYCLE_W-1:0]    cycle    [stm_pkg::NUM_SEGMENT];
  wire [stm_pkg::FREQ_DIV_W-1:0] freq_div [stm_pkg::NUM_SEGMENT];
  wire [stm_pkg::CYCLE_W-1:0]    idx      [stm_pkg::NUM_SEGMENT];
  wire                           busy;

  sys_time_counter u_sys_time_counter (
    .CLK       (CLK),
    .rst_n     (rst_n),
    .time_load (time_load),
    .time_value(time_value),
    .sys_time  (sys_time)
  );

  stm_settings u_stm_settings (
    .CLK      (CLK),
    .rst_n    (rst_n),
    .cfg_we   (cfg_we),
    .cfg_addr (cfg_addr),
    .cfg_wdata(cfg_wdata),
    .cycle    (cycle),
    .freq_div (freq_div)
  );

  stm_timer #(
    .DIV_LATENCY(DIV_LATENCY)
  ) u_stm_timer (
    .CLK        (CLK),
    .rst_n      (rst_n),
    .update_req (update_req),
    .sys_time   (sys_time),
    .cycle      (cycle),
    .freq_div   (freq_div),
    .idx        (idx),
    .update_done(update_done),
    .busy       (busy)
  );

  stm_segment_select u_stm_segment_select (
    .CLK           (CLK),
    .rst_n         (rst_n),
    .update_req    (update_req),
    .busy          (busy),
    .req_segment   (req_segment),
    .update_done   (update_done),
    .idx           (idx),
    .idx_out       (idx_out),
    .active_segment(active_segment)
  );

endmodule

`default_nettype wire

// File: logic/stm_segment_select.sv
`default_nettype none

// Tracks the requested and the active segment and registers the active index
module stm_segment_select (
  input  wire                            CLK,
  input  wire                            rst_n,
  input  wire                            update_req,
  input  wire                            busy,
  input  wire  [stm_pkg::SEGMENT_W-1:0]  req_segment,
  input  wire                            update_done,
  input  wire  [stm_pkg::CYCLE_W-1:0]    idx [stm_pkg::NUM_SEGMENT],
  output logic [stm_pkg::CYCLE_W-1:0]    idx_out,
  output logic [stm_pkg::SEGMENT_W-1:0]  active_segment
);

  logic [stm_pkg::SEGMENT_W-1:0] pending_segment;
  logic [stm_pkg::SEGMENT_W-1:0] next_segment;

  // The timer takes a request under the same condition
  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      pending_segment <= '0;
      active_segment  <= '0;
    end else begin
      if (update_req && !busy) begin
        pending_segment <= req_segment;
      end
      if (update_done) begin
        active_segment <= pending_segment;
      end
    end
  end

  // Look ahead so the index register switches together with active_segment
  assign next_segment = update_done ? pending_segment : active_segment;

  always_ff @(posedge CLK) begin
    idx_out <= idx[next_segment];
  end

endmodule

`default_nettype wire

// File: logic/stm_timer.sv
`default_nettype none

// Sample index per segment: (coarse time / freq_div) mod (cycle + 1). The index
// in a cycle comes from the system time 2 * DIV_LATENCY + 3 cycles earlier
module stm_timer #(
  parameter int DIV_LATENCY = 50
) (
  input  wire                              CLK,
  input  wire                              rst_n,
  input  wire                              update_req,
  input  wire  [stm_pkg::SYS_TIME_W-1:0]   sys_time,
  input  wire  [stm_pkg::CYCLE_W-1:0]      cycle    [stm_pkg::NUM_SEGMENT],
  input  wire  [stm_pkg::FREQ_DIV_W-1:0]   freq_div [stm_pkg::NUM_SEGMENT],
  output wire  [stm_pkg::CYCLE_W-1:0]      idx      [stm_pkg::NUM_SEGMENT],
  output logic                             update_done,
  output logic                             busy
);

  // Edges from the accepting edge to the one that raises update_done
  localparam int LOAD_CYCLES = 2 * DIV_LATENCY + 2;
  localparam int CNT_W       = $clog2(LOAD_CYCLES + 1);

  typedef enum logic {
    IDLE,
    LOAD
  } state_t;

  state_t                            state;
  logic   [CNT_W-1:0]                cnt;
  logic                              accept;
  logic   [stm_pkg::COARSE_TIME_W-1:0] coarse_time;

  assign busy   = (state == LOAD);
  assign accept = (state == IDLE) && update_req;

  always_ff @(posedge CLK) begin
    coarse_time <= sys_time[stm_pkg::TIME_SHIFT +: stm_pkg::COARSE_TIME_W];
  end

  for (genvar i = 0; i < stm_pkg::NUM_SEGMENT; i++) begin : g_segment
    logic [stm_pkg::FREQ_DIV_W-1:0]    freq_div_q;
    logic [stm_pkg::FREQ_DIV_W-1:0]    modulus_q;
    logic [stm_pkg::COARSE_TIME_W-1:0] quo;
    logic [stm_pkg::COARSE_TIME_W-1:0] quo_buf;
    logic [stm_pkg::FREQ_DIV_W-1:0]    rem;
    logic [stm_pkg::CYCLE_W-1:0]       idx_q;

    assign idx[i] = idx_q;

    // Settings in use, replaced only when a request is accepted
    always_ff @(posedge CLK or negedge rst_n) begin
      if (!rst_n) begin
        freq_div_q <= stm_pkg::FREQ_DIV_W'(1);
        modulus_q  <= stm_pkg::FREQ_DIV_W'(1);
      end else if (accept) begin
        freq_div_q <= freq_div[i];
        modulus_q  <= stm_pkg::FREQ_DIV_W'(cycle[i]) + stm_pkg::FREQ_DIV_W'(1);
      end
    end

    always_ff @(posedge CLK) begin
      quo_buf <= quo;
      idx_q   <= rem[stm_pkg::CYCLE_W-1:0];  // Remainder never exceeds the cycle setting
    end

    pipe_divider #(
      .DIVIDEND_W(stm_pkg::COARSE_TIME_W),
      .DIVISOR_W (stm_pkg::FREQ_DIV_W)
    ) u_div_cnt (
      .CLK      (CLK),
      .dividend (coarse_time),
      .divisor  (freq_div_q),
      .quotient (quo),
      .remainder()
    );

    pipe_divider #(
      .DIVIDEND_W(stm_pkg::COARSE_TIME_W),
      .DIVISOR_W (stm_pkg::FREQ_DIV_W)
    ) u_div_idx (
      .CLK      (CLK),
      .dividend (quo_buf),
      .divisor  (modulus_q),
      .quotient (),
      .remainder(rem)
    );
  end

  // Waits until both pipelines hold only results of the new settings
  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      state       <= IDLE;
      cnt         <= '0;
      update_done <= 1'b0;
    end else begin
      case (state)
        IDLE: begin
          update_done <= 1'b0;
          cnt         <= '0;
          if (update_req) begin
            state <= LOAD;
          end
        end
        LOAD: begin
          cnt <= cnt + 1'b1;
          if (cnt == CNT_W'(LOAD_CYCLES)) begin
            update_done <= 1'b1;
            state       <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: logic/stm_settings.sv
`default_nettype none

// Cycle length and frequency divider of each segment, written by the host
module stm_settings (
  input  wire                            CLK,
  input  wire                            rst_n,
  input  wire                            cfg_we,
  input  wire  [stm_pkg::CFG_ADDR_W-1:0] cfg_addr,
  input  wire  [stm_pkg::FREQ_DIV_W-1:0] cfg_wdata,
  output logic [stm_pkg::CYCLE_W-1:0]    cycle    [stm_pkg::NUM_SEGMENT],
  output logic [stm_pkg::FREQ_DIV_W-1:0] freq_div [stm_pkg::NUM_SEGMENT]
);

  logic [stm_pkg::SEGMENT_W-1:0] wr_segment;
  logic                          wr_freq_div;

  // Bit 0 picks the field and the bits above it the segment
  assign wr_freq_div = cfg_addr[0];
  assign wr_segment  = cfg_addr[1 +: stm_pkg::SEGMENT_W];

  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      for (int s = 0; s < stm_pkg::NUM_SEGMENT; s++) begin
        cycle[s]    <= '0;
        freq_div[s] <= stm_pkg::FREQ_DIV_W'(1);
      end
    end else if (cfg_we) begin
      if (wr_freq_div) begin
        freq_div[wr_segment] <= cfg_wdata;
      end else begin
        // Only the low bits of a cycle write are kept
        cycle[wr_segment] <= cfg_wdata[stm_pkg::CYCLE_W-1:0];
      end
    end
  end

endmodule

`default_nettype wire

// File: logic/sys_time_counter.sv
`default_nettype none

// Free-running time base, loadable by the host
module sys_time_counter (
  input  wire                            CLK,
  input  wire                            rst_n,
  input  wire                            time_load,
  input  wire  [stm_pkg::SYS_TIME_W-1:0] time_value,
  output logic [stm_pkg::SYS_TIME_W-1:0] sys_time
);

  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      sys_time <= '0;
    end else if (time_load) begin
      sys_time <= time_value;  // Counting resumes from the loaded value
    end else begin
      sys_time <= sys_time + 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: logic/pipe_divider.sv
`default_nettype none

// Restoring divider with one subtract stage per dividend bit. The quotient and
// remainder of an operand pair appear DIVIDEND_W + 2 cycles after it is applied
module pipe_divider #(
  parameter int DIVIDEND_W = 48,
  parameter int DIVISOR_W  = 16
) (
  input  wire                   CLK,
  input  wire  [DIVIDEND_W-1:0] dividend,
  input  wire  [DIVISOR_W-1:0]  divisor,
  output logic [DIVIDEND_W-1:0] quotient,
  output logic [DIVISOR_W-1:0]  remainder
);

  // Stage s holds the partial remainder, and a word whose top bits are the
  // dividend bits still to process and whose low bits are the quotient so far
  logic [DIVIDEND_W-1:0] quo_q [DIVIDEND_W+1];
  logic [DIVISOR_W-1:0]  rem_q [DIVIDEND_W+1];
  logic [DIVISOR_W-1:0]  dvs_q [DIVIDEND_W];

  logic [DIVISOR_W:0]    trial    [DIVIDEND_W];
  logic [DIVISOR_W:0]    diff     [DIVIDEND_W];
  logic [DIVIDEND_W-1:0] fits;
  logic [DIVISOR_W-1:0]  next_rem [DIVIDEND_W];
  logic [DIVIDEND_W-1:0] next_quo [DIVIDEND_W];

  always_comb begin
    for (int s = 0; s < DIVIDEND_W; s++) begin
      // Bring down the next dividend bit
      trial[s] = {rem_q[s], quo_q[s][DIVIDEND_W-1]};
      fits[s]  = trial[s] >= {1'b0, dvs_q[s]};
      diff[s]  = trial[s] - {1'b0, dvs_q[s]};
      // Either result is below the divisor, so the top bit is always zero
      next_rem[s] = fits[s] ? diff[s][DIVISOR_W-1:0] : trial[s][DIVISOR_W-1:0];
      next_quo[s] = {quo_q[s][DIVIDEND_W-2:0], fits[s]};
    end
  end

  // A zero divisor always fits, which gives an all-ones quotient and leaves
  // the low dividend bits in the remainder
  always_ff @(posedge CLK) begin
    quo_q[0] <= dividend;
    rem_q[0] <= '0;
    dvs_q[0] <= divisor;
    for (int s = 0; s < DIVIDEND_W; s++) begin
      quo_q[s+1] <= next_quo[s];
      rem_q[s+1] <= next_rem[s];
    end
    for (int s = 1; s < DIVIDEND_W; s++) begin
      dvs_q[s] <= dvs_q[s-1];  // The last stage needs no copy of its own
    end
    quotient  <= quo_q[DIVIDEND_W];
    remainder <= rem_q[DIVIDEND_W];
  end

endmodule

`default_nettype wire

// File: logic/stm_pkg.sv
`default_nettype none

package stm_pkg;

  // Number of STM segments handled by the timer
  localparam int NUM_SEGMENT = 2;

  // Width of the segment select fields
  localparam int SEGMENT_W = $clog2(NUM_SEGMENT);

  // Cycle setting and sample index width. The modulus is the setting plus one
  localparam int CYCLE_W = 13;

  localparam int FREQ_DIV_W = 16;  // Frequency divider width

  localparam int SYS_TIME_W = 64;  // Free-running system time

  // Low system time bits dropped before the division
  localparam int TIME_SHIFT = 8;

  localparam int COARSE_TIME_W = 48;  // Dividend width of the first divider

  // Settings address. Bit 0 picks the field, bit 1 picks the segment
  localparam int CFG_ADDR_W = 2;

endpackage

`default_nettype wire
